// ==== hw/gemm_pkg.sv ====
// shared widths and encodings for the GEMM subsystem
// ACC_W covers the sum of four 8x8 signed products, so SA_WIDTH must stay at 4 or below

package gemm_pkg;

    // signed matrix element
    localparam int ELEM_W = 8;
    // memory word, register and byte address
    localparam int WORD_W = 32;
    // one C accumulator
    localparam int ACC_W  = 18;

    // register word index on the config bus
    typedef enum logic [2:0] {
        REG_A_ADDR = 3'd0,
        REG_B_ADDR = 3'd1,
        REG_C_ADDR = 3'd2,
        REG_CTRL   = 3'd3,
        REG_STATUS = 3'd4
    } reg_addr_e;

    typedef enum logic [2:0] {
        IDLE,
        READ_A,
        READ_B,
        WAIT_MM,
        WRITE_C
    } dma_state_e;

    typedef enum logic [0:0] {
        MM_IDLE,
        MM_RUN
    } mm_state_e;

endpackage

// ==== hw/gemm_cfg_regs.sv ====
// config and status registers for one GEMM job
// read data is registered, valid the cycle after reg_rd_i
// address writes while busy are dropped; start is combinational from the bus write

`timescale 1ns/1ps

module gemm_cfg_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          reg_wr_i,
    input  logic                          reg_rd_i,
    input  gemm_pkg::reg_addr_e           reg_addr_i,
    input  logic [gemm_pkg::WORD_W-1:0]   reg_wdata_i,
    output logic [gemm_pkg::WORD_W-1:0]   reg_rdata_o,
    input  logic                          busy_i,
    input  logic                          dma_done_i,
    output logic [gemm_pkg::WORD_W-1:0]   a_addr_o,
    output logic [gemm_pkg::WORD_W-1:0]   b_addr_o,
    output logic [gemm_pkg::WORD_W-1:0]   c_addr_o,
    output logic                          start_o
);

    logic done_q;
    logic addr_wr_ok;

    // ctrl bit 0 write only counts when idle
    assign start_o = reg_wr_i && (reg_addr_i == gemm_pkg::REG_CTRL)
                     && reg_wdata_i[0] && !busy_i;

    assign addr_wr_ok = reg_wr_i && !busy_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_addr_o <= '0;
            b_addr_o <= '0;
            c_addr_o <= '0;
        end else if (addr_wr_ok) begin
            case (reg_addr_i)
                gemm_pkg::REG_A_ADDR: a_addr_o <= reg_wdata_i;
                gemm_pkg::REG_B_ADDR: b_addr_o <= reg_wdata_i;
                gemm_pkg::REG_C_ADDR: c_addr_o <= reg_wdata_i;
                default: ;
            endcase
        end
    end

    // sticky done, cleared by the next accepted start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else if (start_o) begin
            done_q <= 1'b0;
        end else if (dma_done_i) begin
            done_q <= 1'b1;
        end
    end

    // read decode, ctrl reads back as zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_rdata_o <= '0;
        end else if (reg_rd_i) begin
            case (reg_addr_i)
                gemm_pkg::REG_A_ADDR: reg_rdata_o <= a_addr_o;
                gemm_pkg::REG_B_ADDR: reg_rdata_o <= b_addr_o;
                gemm_pkg::REG_C_ADDR: reg_rdata_o <= c_addr_o;
                gemm_pkg::REG_STATUS: reg_rdata_o <= {30'd0, done_q, busy_i};
                default:              reg_rdata_o <= '0;
            endcase
        end
    end

endmodule

// ==== hw/gemm_row_buf.sv ====
// row buffer, SA_WIDTH packed rows, one write port
// read data is registered, one cycle after rd_row_i

`timescale 1ns/1ps

module gemm_row_buf #(
    parameter int SA_WIDTH = 4
) (
    input  logic                                   clk,
    input  logic                                   wr_i,
    input  logic [$clog2(SA_WIDTH)-1:0]            wr_row_i,
    input  logic [SA_WIDTH*gemm_pkg::ELEM_W-1:0]   wr_data_i,
    input  logic [$clog2(SA_WIDTH)-1:0]            rd_row_i,
    output logic [SA_WIDTH*gemm_pkg::ELEM_W-1:0]   rd_data_o
);

    localparam int ROW_DW = SA_WIDTH * gemm_pkg::ELEM_W;

    logic [ROW_DW-1:0] mem [SA_WIDTH];

    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[wr_row_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_row_i];
    end

endmodule

// ==== hw/gemm_mm.sv ====
// multiply engine, one (i,k) pair per cycle, SA_WIDTH MACs per cycle
// done pulses SA_WIDTH^2 + 2 cycles after start given 1-cycle buffer reads
// accumulators clear on start, not on reset

`timescale 1ns/1ps

module gemm_mm #(
    parameter int SA_WIDTH = 4
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start_i,
    output logic                                   done_o,
    output logic [$clog2(SA_WIDTH)-1:0]            a_row_o,
    output logic [$clog2(SA_WIDTH)-1:0]            b_row_o,
    input  logic [SA_WIDTH*gemm_pkg::ELEM_W-1:0]   a_data_i,
    input  logic [SA_WIDTH*gemm_pkg::ELEM_W-1:0]   b_data_i,
    input  logic [$clog2(SA_WIDTH*SA_WIDTH)-1:0]   c_idx_i,
    output logic signed [gemm_pkg::ACC_W-1:0]      c_data_o
);

    localparam int ROW_W = $clog2(SA_WIDTH);
    localparam int EW    = gemm_pkg::ELEM_W;

    gemm_pkg::mm_state_e               state;
    logic [ROW_W-1:0]                  i_q, k_q;
    logic [ROW_W-1:0]                  i_d, k_d;
    logic                              vld_d, last_d;
    logic                              last_pair;
    logic signed [EW-1:0]              a_elem;
    logic signed [2*EW-1:0]            prod [SA_WIDTH];
    logic signed [gemm_pkg::ACC_W-1:0] acc [SA_WIDTH*SA_WIDTH];

    assign last_pair = (i_q == ROW_W'(SA_WIDTH - 1)) && (k_q == ROW_W'(SA_WIDTH - 1));

    // issue stage, buffer address straight from the pair counters
    assign a_row_o = i_q;
    assign b_row_o = k_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= gemm_pkg::MM_IDLE;
            i_q    <= '0;
            k_q    <= '0;
            vld_d  <= 1'b0;
            last_d <= 1'b0;
            done_o <= 1'b0;
        end else begin
            vld_d  <= (state == gemm_pkg::MM_RUN);
            last_d <= (state == gemm_pkg::MM_RUN) && last_pair;
            // done once the last pair has been accumulated
            done_o <= last_d;
            case (state)
                gemm_pkg::MM_IDLE: begin
                    if (start_i) begin
                        i_q   <= '0;
                        k_q   <= '0;
                        state <= gemm_pkg::MM_RUN;
                    end
                end
                gemm_pkg::MM_RUN: begin
                    // k inner, i outer
                    if (k_q == ROW_W'(SA_WIDTH - 1)) begin
                        k_q <= '0;
                        i_q <= i_q + 1'b1;
                    end else begin
                        k_q <= k_q + 1'b1;
                    end
                    if (last_pair) begin
                        state <= gemm_pkg::MM_IDLE;
                    end
                end
                default: state <= gemm_pkg::MM_IDLE;
            endcase
        end
    end

    // pair indices follow the buffer read by one cycle
    always_ff @(posedge clk) begin
        i_d <= i_q;
        k_d <= k_q;
    end

    // A[i][k] broadcast against row k of B
    assign a_elem = a_data_i[k_d*EW +: EW];

    always_comb begin
        for (int j = 0; j < SA_WIDTH; j++) begin
            prod[j] = a_elem * $signed(b_data_i[j*EW +: EW]);
        end
    end

    always_ff @(posedge clk) begin
        for (int n = 0; n < SA_WIDTH * SA_WIDTH; n++) begin
            if (start_i) begin
                acc[n] <= '0;
            end
        end
        if (vld_d) begin
            for (int j = 0; j < SA_WIDTH; j++) begin
                acc[i_d*SA_WIDTH + j] <= acc[i_d*SA_WIDTH + j] + prod[j];
            end
        end
    end

    // row-major readout for the store phase
    assign c_data_o = acc[c_idx_i];

endmodule

// ==== hw/gemm_dma.sv ====
// DMA sequencer: loads A then B row by row, runs the multiply, stores C
// one read outstanding at a time, writes are posted and never stall
// each C element goes out as one sign-extended 32-bit word

`timescale 1ns/1ps

module gemm_dma #(
    parameter int SA_WIDTH = 4
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic [gemm_pkg::WORD_W-1:0]                a_addr_i,
    input  logic [gemm_pkg::WORD_W-1:0]                b_addr_i,
    input  logic [gemm_pkg::WORD_W-1:0]                c_addr_i,
    input  logic                                       start_i,
    output logic                                       busy_o,
    output logic                                       done_o,
    output logic                                       mem_rd_req_o,
    output logic [gemm_pkg::WORD_W-1:0]                mem_rd_addr_o,
    input  logic                                       mem_rd_valid_i,
    input  logic [gemm_pkg::WORD_W-1:0]                mem_rd_data_i,
    output logic                                       mem_wr_o,
    output logic [gemm_pkg::WORD_W-1:0]                mem_wr_addr_o,
    output logic [gemm_pkg::WORD_W-1:0]                mem_wr_data_o,
    output logic                                       buf_a_wr_o,
    output logic                                       buf_b_wr_o,
    output logic [$clog2(SA_WIDTH)-1:0]                buf_wr_row_o,
    output logic [SA_WIDTH*gemm_pkg::ELEM_W-1:0]       buf_wr_data_o,
    output logic                                       mm_start_o,
    input  logic                                       mm_done_i,
    output logic [$clog2(SA_WIDTH*SA_WIDTH)-1:0]       c_idx_o,
    input  logic signed [gemm_pkg::ACC_W-1:0]          c_data_i
);

    localparam int ROW_W    = $clog2(SA_WIDTH);
    localparam int IDX_W    = $clog2(SA_WIDTH * SA_WIDTH);
    localparam int ROW_DW   = SA_WIDTH * gemm_pkg::ELEM_W;
    localparam int LAST_ROW = SA_WIDTH - 1;
    localparam int LAST_IDX = SA_WIDTH * SA_WIDTH - 1;
    localparam int EXT_W    = gemm_pkg::WORD_W - gemm_pkg::ACC_W;

    gemm_pkg::dma_state_e             state;
    logic [ROW_W-1:0]                 row_cnt;
    logic [IDX_W-1:0]                 elem_cnt;
    logic [gemm_pkg::WORD_W-1:0]      b_base;
    logic [gemm_pkg::WORD_W-1:0]      c_base;
    logic                             last_row;

    assign last_row = (row_cnt == ROW_W'(LAST_ROW));
    assign busy_o   = (state != gemm_pkg::IDLE);

    // bases held for the whole job, A base only needed for the first request
    always_ff @(posedge clk) begin
        if (state == gemm_pkg::IDLE && start_i) begin
            b_base <= b_addr_i;
            c_base <= c_addr_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= gemm_pkg::IDLE;
            row_cnt       <= '0;
            elem_cnt      <= '0;
            mem_rd_req_o  <= 1'b0;
            mem_rd_addr_o <= '0;
            mm_start_o    <= 1'b0;
            done_o        <= 1'b0;
        end else begin
            // strobes default low
            mem_rd_req_o <= 1'b0;
            mm_start_o   <= 1'b0;
            done_o       <= 1'b0;
            case (state)
                gemm_pkg::IDLE: begin
                    if (start_i) begin
                        row_cnt       <= '0;
                        mem_rd_req_o  <= 1'b1;
                        mem_rd_addr_o <= a_addr_i;
                        state         <= gemm_pkg::READ_A;
                    end
                end
                gemm_pkg::READ_A: begin
                    // wait out the read latency, next request right after valid
                    if (mem_rd_valid_i) begin
                        mem_rd_req_o <= 1'b1;
                        if (last_row) begin
                            row_cnt       <= '0;
                            mem_rd_addr_o <= b_base;
                            state         <= gemm_pkg::READ_B;
                        end else begin
                            row_cnt       <= row_cnt + 1'b1;
                            mem_rd_addr_o <= mem_rd_addr_o + 32'd4;
                        end
                    end
                end
                gemm_pkg::READ_B: begin
                    if (mem_rd_valid_i) begin
                        if (last_row) begin
                            // last B row lands this cycle, kick the multiply next
                            mm_start_o <= 1'b1;
                            state      <= gemm_pkg::WAIT_MM;
                        end else begin
                            row_cnt       <= row_cnt + 1'b1;
                            mem_rd_req_o  <= 1'b1;
                            mem_rd_addr_o <= mem_rd_addr_o + 32'd4;
                        end
                    end
                end
                gemm_pkg::WAIT_MM: begin
                    if (mm_done_i) begin
                        elem_cnt <= '0;
                        state    <= gemm_pkg::WRITE_C;
                    end
                end
                gemm_pkg::WRITE_C: begin
                    // one write per cycle, row-major
                    if (elem_cnt == IDX_W'(LAST_IDX)) begin
                        done_o <= 1'b1;
                        state  <= gemm_pkg::IDLE;
                    end else begin
                        elem_cnt <= elem_cnt + 1'b1;
                    end
                end
                default: state <= gemm_pkg::IDLE;
            endcase
        end
    end

    // returned row goes straight into the buffer picked by the state
    assign buf_a_wr_o    = (state == gemm_pkg::READ_A) && mem_rd_valid_i;
    assign buf_b_wr_o    = (state == gemm_pkg::READ_B) && mem_rd_valid_i;
    assign buf_wr_row_o  = row_cnt;
    assign buf_wr_data_o = mem_rd_data_i[ROW_DW-1:0];

    // C store path
    assign mem_wr_o      = (state == gemm_pkg::WRITE_C);
    assign c_idx_o       = elem_cnt;
    assign mem_wr_addr_o = c_base + (gemm_pkg::WORD_W'(elem_cnt) << 2);
    assign mem_wr_data_o = {{EXT_W{c_data_i[gemm_pkg::ACC_W-1]}}, c_data_i};

endmodule

// ==== hw/gemm_top.sv ====
// GEMM subsystem top: registers, DMA, A/B row buffers and multiply engine
// SA_WIDTH is 2 to 4, one packed row per 32-bit memory word

`timescale 1ns/1ps

module gemm_top #(
    parameter int SA_WIDTH = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // register bus
    input  logic                          reg_wr_i,
    input  logic                          reg_rd_i,
    input  gemm_pkg::reg_addr_e           reg_addr_i,
    input  logic [gemm_pkg::WORD_W-1:0]   reg_wdata_i,
    output logic [gemm_pkg::WORD_W-1:0]   reg_rdata_o,
    // memory strobes
    output logic                          mem_rd_req_o,
    output logic [gemm_pkg::WORD_W-1:0]   mem_rd_addr_o,
    input  logic                          mem_rd_valid_i,
    input  logic [gemm_pkg::WORD_W-1:0]   mem_rd_data_i,
    output logic                          mem_wr_o,
    output logic [gemm_pkg::WORD_W-1:0]   mem_wr_addr_o,
    output logic [gemm_pkg::WORD_W-1:0]   mem_wr_data_o
);

    localparam int ROW_W  = $clog2(SA_WIDTH);
    localparam int IDX_W  = $clog2(SA_WIDTH * SA_WIDTH);
    localparam int ROW_DW = SA_WIDTH * gemm_pkg::ELEM_W;

    logic [gemm_pkg::WORD_W-1:0]       a_addr, b_addr, c_addr;
    logic                              start, busy, dma_done;
    logic                              buf_a_wr, buf_b_wr;
    logic [ROW_W-1:0]                  buf_wr_row;
    logic [ROW_DW-1:0]                 buf_wr_data;
    logic [ROW_W-1:0]                  a_row, b_row;
    logic [ROW_DW-1:0]                 a_data, b_data;
    logic                              mm_start, mm_done;
    logic [IDX_W-1:0]                  c_idx;
    logic signed [gemm_pkg::ACC_W-1:0] c_data;

    gemm_cfg_regs i_regs (
        .clk(clk), .rst_n(rst_n),
        .reg_wr_i(reg_wr_i), .reg_rd_i(reg_rd_i), .reg_addr_i(reg_addr_i),
        .reg_wdata_i(reg_wdata_i), .reg_rdata_o(reg_rdata_o),
        .busy_i(busy), .dma_done_i(dma_done),
        .a_addr_o(a_addr), .b_addr_o(b_addr), .c_addr_o(c_addr), .start_o(start)
    );

    gemm_dma #(.SA_WIDTH(SA_WIDTH)) i_dma (
        .clk(clk), .rst_n(rst_n),
        .a_addr_i(a_addr), .b_addr_i(b_addr), .c_addr_i(c_addr),
        .start_i(start), .busy_o(busy), .done_o(dma_done),
        .mem_rd_req_o(mem_rd_req_o), .mem_rd_addr_o(mem_rd_addr_o),
        .mem_rd_valid_i(mem_rd_valid_i), .mem_rd_data_i(mem_rd_data_i),
        .mem_wr_o(mem_wr_o), .mem_wr_addr_o(mem_wr_addr_o), .mem_wr_data_o(mem_wr_data_o),
        .buf_a_wr_o(buf_a_wr), .buf_b_wr_o(buf_b_wr),
        .buf_wr_row_o(buf_wr_row), .buf_wr_data_o(buf_wr_data),
        .mm_start_o(mm_start), .mm_done_i(mm_done),
        .c_idx_o(c_idx), .c_data_i(c_data)
    );

    // A and B share the DMA write row and data, separate enables
    gemm_row_buf #(.SA_WIDTH(SA_WIDTH)) i_buf_a (
        .clk(clk), .wr_i(buf_a_wr), .wr_row_i(buf_wr_row), .wr_data_i(buf_wr_data),
        .rd_row_i(a_row), .rd_data_o(a_data)
    );

    gemm_row_buf #(.SA_WIDTH(SA_WIDTH)) i_buf_b (
        .clk(clk), .wr_i(buf_b_wr), .wr_row_i(buf_wr_row), .wr_data_i(buf_wr_data),
        .rd_row_i(b_row), .rd_data_o(b_data)
    );

    gemm_mm #(.SA_WIDTH(SA_WIDTH)) i_mm (
        .clk(clk), .rst_n(rst_n),
        .start_i(mm_start), .done_o(mm_done),
        .a_row_o(a_row), .b_row_o(b_row), .a_data_i(a_data), .b_data_i(b_data),
        .c_idx_i(c_idx), .c_data_o(c_data)
    );

endmodule

// ==== verif/gemm_tb.sv ====
// directed testbench for gemm_top with SA_WIDTH 4
// memory model covers byte addresses 0 to 4095 only, read latency 1 to 4 cycles

`timescale 1ns/1ps

module gemm_tb;

    localparam int SA_WIDTH = 4;
    localparam int N_ELEM   = SA_WIDTH * SA_WIDTH;

    logic                                clk;
    logic                                rst_n;
    logic                                reg_wr_i;
    logic                                reg_rd_i;
    gemm_pkg::reg_addr_e                 reg_addr_i;
    logic [gemm_pkg::WORD_W-1:0]         reg_wdata_i;
    logic [gemm_pkg::WORD_W-1:0]         reg_rdata_o;
    logic                                mem_rd_req_o;
    logic [gemm_pkg::WORD_W-1:0]         mem_rd_addr_o;
    logic                                mem_rd_valid_i;
    logic [gemm_pkg::WORD_W-1:0]         mem_rd_data_i;
    logic                                mem_wr_o;
    logic [gemm_pkg::WORD_W-1:0]         mem_wr_addr_o;
    logic [gemm_pkg::WORD_W-1:0]         mem_wr_data_o;

    // word memory, indexed by byte address bits 11:2
    logic [gemm_pkg::WORD_W-1:0]         mem [1024];
    int                                  lat_tab [256];
    logic [gemm_pkg::WORD_W-1:0]         wr_addr_q [$];
    // operands and expected C, row-major
    logic signed [gemm_pkg::ELEM_W-1:0]  ma [N_ELEM];
    logic signed [gemm_pkg::ELEM_W-1:0]  mb [N_ELEM];
    logic signed [gemm_pkg::ACC_W-1:0]   exp_c [N_ELEM];

    gemm_top #(.SA_WIDTH(SA_WIDTH)) i_gemm_top (
        .clk(clk), .rst_n(rst_n),
        .reg_wr_i(reg_wr_i), .reg_rd_i(reg_rd_i), .reg_addr_i(reg_addr_i),
        .reg_wdata_i(reg_wdata_i), .reg_rdata_o(reg_rdata_o),
        .mem_rd_req_o(mem_rd_req_o), .mem_rd_addr_o(mem_rd_addr_o),
        .mem_rd_valid_i(mem_rd_valid_i), .mem_rd_data_i(mem_rd_data_i),
        .mem_wr_o(mem_wr_o), .mem_wr_addr_o(mem_wr_addr_o), .mem_wr_data_o(mem_wr_data_o)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // read side of the memory model, one request at a time
    initial begin : read_responder
        logic [gemm_pkg::WORD_W-1:0] addr;
        int                          lat;
        int                          n_rd;
        mem_rd_valid_i = 1'b0;
        mem_rd_data_i  = '0;
        n_rd           = 0;
        forever begin
            @(posedge clk);
            if (rst_n && mem_rd_req_o) begin
                addr = mem_rd_addr_o;
                lat  = lat_tab[n_rd % 256];
                n_rd++;
                repeat (lat - 1) @(posedge clk);
                #1;
                mem_rd_valid_i = 1'b1;
                mem_rd_data_i  = mem[addr[11:2]];
                @(posedge clk);
                #1;
                mem_rd_valid_i = 1'b0;
            end
        end
    end

    // write side, posted, also logs every address
    always @(posedge clk) begin
        if (rst_n && mem_wr_o) begin
            mem[mem_wr_addr_o[11:2]] = mem_wr_data_o;
            wr_addr_q.push_back(mem_wr_addr_o);
        end
    end

    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic check_reg(input string test, input string what,
                             input logic [gemm_pkg::WORD_W-1:0] exp,
                             input logic [gemm_pkg::WORD_W-1:0] act);
        if (act !== exp) begin
            fail_stop($sformatf("error: %s %s expected %h actual %h", test, what, exp, act));
        end
    endtask

    // expected element sign-extended to the stored word
    task automatic check_elem(input string test, input int idx,
                              input logic signed [gemm_pkg::ACC_W-1:0] exp,
                              input logic [gemm_pkg::WORD_W-1:0] act);
        logic [gemm_pkg::WORD_W-1:0] exp_w;
        exp_w = {{(gemm_pkg::WORD_W - gemm_pkg::ACC_W){exp[gemm_pkg::ACC_W-1]}}, exp};
        if (act !== exp_w) begin
            fail_stop($sformatf("error: %s c[%0d] expected %h actual %h",
                                test, idx, exp_w, act));
        end
    endtask

    task automatic check_count(input string test, input string what, input int exp,
                               input int act);
        if (act != exp) begin
            fail_stop($sformatf("error: %s %s expected %0d actual %0d", test, what, exp, act));
        end
    endtask

    task automatic reg_write(input gemm_pkg::reg_addr_e addr,
                             input logic [gemm_pkg::WORD_W-1:0] data);
        @(posedge clk);
        #1;
        reg_wr_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(posedge clk);
        #1;
        reg_wr_i = 1'b0;
    endtask

    // rdata is registered, sampled after the edge that captured it
    task automatic reg_read(input gemm_pkg::reg_addr_e addr,
                            output logic [gemm_pkg::WORD_W-1:0] data);
        @(posedge clk);
        #1;
        reg_rd_i   = 1'b1;
        reg_addr_i = addr;
        @(posedge clk);
        #1;
        reg_rd_i = 1'b0;
        data     = reg_rdata_o;
    endtask

    // packs ma or mb into SA_WIDTH row words at base
    task automatic load_matrix(input logic [gemm_pkg::WORD_W-1:0] base, input bit sel_b);
        logic [gemm_pkg::WORD_W-1:0] row;
        for (int r = 0; r < SA_WIDTH; r++) begin
            row = '0;
            for (int j = 0; j < SA_WIDTH; j++) begin
                row[j*gemm_pkg::ELEM_W +: gemm_pkg::ELEM_W] =
                    sel_b ? mb[r*SA_WIDTH + j] : ma[r*SA_WIDTH + j];
            end
            mem[base[11:2] + r] = row;
        end
    endtask

    task automatic random_matrices();
        for (int n = 0; n < N_ELEM; n++) begin
            ma[n] = 8'($urandom_range(255, 0));
            mb[n] = 8'($urandom_range(255, 0));
        end
        // extremes: row 0 of A and column 0 of B at -128, plus a few 127s
        for (int k = 0; k < SA_WIDTH; k++) begin
            ma[k]            = 8'h80;
            mb[k * SA_WIDTH] = 8'h80;
        end
        ma[N_ELEM-1] = 8'h7f;
        mb[N_ELEM-1] = 8'h7f;
        mb[6]        = 8'h7f;
    endtask

    // C = A * B, plain integer sums
    task automatic ref_mult();
        int sum;
        for (int i = 0; i < SA_WIDTH; i++) begin
            for (int j = 0; j < SA_WIDTH; j++) begin
                sum = 0;
                for (int k = 0; k < SA_WIDTH; k++) begin
                    sum = sum + ma[i*SA_WIDTH + k] * mb[k*SA_WIDTH + j];
                end
                exp_c[i*SA_WIDTH + j] = gemm_pkg::ACC_W'(sum);
            end
        end
    endtask

    task automatic start_job(input logic [gemm_pkg::WORD_W-1:0] a_base,
                             input logic [gemm_pkg::WORD_W-1:0] b_base,
                             input logic [gemm_pkg::WORD_W-1:0] c_base);
        reg_write(gemm_pkg::REG_A_ADDR, a_base);
        reg_write(gemm_pkg::REG_B_ADDR, b_base);
        reg_write(gemm_pkg::REG_C_ADDR, c_base);
        wr_addr_q.delete();
        reg_write(gemm_pkg::REG_CTRL, 32'h1);
    endtask

    // poll status until done, bounded
    task automatic wait_done(input string test);
        logic [gemm_pkg::WORD_W-1:0] st;
        int                          polls;
        st    = '0;
        polls = 0;
        while (!st[1]) begin
            if (polls == 200) begin
                fail_stop($sformatf("%s: timed out waiting for status done", test));
            end
            reg_read(gemm_pkg::REG_STATUS, st);
            polls++;
        end
        check_reg(test, "status at end", 32'h2, st);
    endtask

    // 16 writes in order at c_base, memory holds expected C
    task automatic check_result(input string test, input logic [gemm_pkg::WORD_W-1:0] c_base);
        check_count(test, "write count", N_ELEM, wr_addr_q.size());
        for (int n = 0; n < N_ELEM; n++) begin
            check_reg(test, "write address", c_base + 32'(4 * n), wr_addr_q[n]);
            check_elem(test, n, exp_c[n], mem[c_base[11:2] + n]);
        end
    endtask

    task automatic run_job(input string test, input logic [gemm_pkg::WORD_W-1:0] a_base,
                           input logic [gemm_pkg::WORD_W-1:0] b_base,
                           input logic [gemm_pkg::WORD_W-1:0] c_base);
        load_matrix(a_base, 1'b0);
        load_matrix(b_base, 1'b1);
        start_job(a_base, b_base, c_base);
        wait_done(test);
        check_result(test, c_base);
    endtask

    task automatic test_reset_regs();
        logic [gemm_pkg::WORD_W-1:0] v;
        reg_read(gemm_pkg::REG_STATUS, v);
        check_reg("reset_regs", "status", 32'h0, v);
        reg_read(gemm_pkg::REG_C_ADDR, v);
        check_reg("reset_regs", "c addr after reset", 32'h0, v);
        reg_write(gemm_pkg::REG_A_ADDR, 32'h1234_5670);
        reg_write(gemm_pkg::REG_B_ADDR, 32'h0bad_cafc);
        reg_write(gemm_pkg::REG_C_ADDR, 32'h8000_0ff0);
        reg_read(gemm_pkg::REG_A_ADDR, v);
        check_reg("reset_regs", "a addr", 32'h1234_5670, v);
        reg_read(gemm_pkg::REG_B_ADDR, v);
        check_reg("reset_regs", "b addr", 32'h0bad_cafc, v);
        reg_read(gemm_pkg::REG_C_ADDR, v);
        check_reg("reset_regs", "c addr", 32'h8000_0ff0, v);
    endtask

    // identity A, so C is B sign-extended
    task automatic test_identity();
        random_matrices();
        for (int n = 0; n < N_ELEM; n++) begin
            ma[n]    = (n / SA_WIDTH == n % SA_WIDTH) ? 8'sd1 : 8'sd0;
            exp_c[n] = mb[n];
        end
        run_job("identity", 32'h100, 32'h200, 32'h400);
    endtask

    task automatic test_random();
        random_matrices();
        ref_mult();
        run_job("random", 32'h140, 32'h240, 32'h480);
    endtask

    // second start and a C base write land while busy
    task automatic test_start_while_busy();
        logic [gemm_pkg::WORD_W-1:0] v;
        random_matrices();
        ref_mult();
        load_matrix(32'h100, 1'b0);
        load_matrix(32'h200, 1'b1);
        start_job(32'h100, 32'h200, 32'h500);
        reg_read(gemm_pkg::REG_STATUS, v);
        check_reg("start_while_busy", "status while busy", 32'h1, v);
        reg_write(gemm_pkg::REG_C_ADDR, 32'h700);
        reg_write(gemm_pkg::REG_CTRL, 32'h1);
        wait_done("start_while_busy");
        check_result("start_while_busy", 32'h500);
        reg_read(gemm_pkg::REG_C_ADDR, v);
        check_reg("start_while_busy", "c addr kept", 32'h500, v);
    endtask

    task automatic test_back_to_back();
        logic [gemm_pkg::WORD_W-1:0] v;
        random_matrices();
        ref_mult();
        run_job("back_to_back_1", 32'h100, 32'h200, 32'h600);
        random_matrices();
        ref_mult();
        load_matrix(32'h300, 1'b0);
        load_matrix(32'h380, 1'b1);
        start_job(32'h300, 32'h380, 32'h800);
        // done from job 1 cleared by this start
        reg_read(gemm_pkg::REG_STATUS, v);
        check_reg("back_to_back_2", "status after start", 32'h1, v);
        wait_done("back_to_back_2");
        check_result("back_to_back_2", 32'h800);
    endtask

    initial begin : main
        rst_n       = 1'b0;
        reg_wr_i    = 1'b0;
        reg_rd_i    = 1'b0;
        reg_addr_i  = gemm_pkg::REG_A_ADDR;
        reg_wdata_i = '0;
        void'($urandom(4080));
        for (int n = 0; n < 256; n++) begin
            lat_tab[n] = $urandom_range(4, 1);
        end
        // fill uses the whole word index
        for (int n = 0; n < 1024; n++) begin
            mem[n] = (32'(n) * 32'h0001_0003) ^ 32'hc3a5_0000;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_regs();
        test_identity();
        test_random();
        test_start_while_busy();
        test_back_to_back();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== build.f ====
hw/gemm_pkg.sv
hw/gemm_cfg_regs.sv
hw/gemm_row_buf.sv
hw/gemm_mm.sv
hw/gemm_dma.sv
hw/gemm_top.sv
verif/gemm_tb.sv
